// ==== Makefile ====
# Verilator flow for the stream monitor testbench

SIM  = obj_dir/Vtb_stream_monitor
SRCS = $(shell grep -v '^+' stream_monitor.f) logic/stream_defs.svh

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): stream_monitor.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_stream_monitor -f stream_monitor.f

# the log decides the result
run: $(SIM)
	$(SIM) > sim.log || true
	@cat sim.log
	@! grep -q "Errors found" sim.log
	@grep -q "No errors" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== logic/axis_pkg.sv ====
/*
  Stream beat type shared by every stage of the monitor.
  A beat is the payload of one transfer, without valid and ready.
  Import with a wildcard in the module header.
*/
`default_nettype none

`include "stream_defs.svh"

package axis_pkg;

    // one beat of the stream, 74 bits in all
    typedef struct packed {
        // payload word
        logic [`STREAM_DATA_W-1:0] data;
        // byte enables, one per data byte
        logic [`STREAM_KEEP_W-1:0] keep;
        // marks the final beat of a frame
        logic                      last;
        // sideband error flag from the source
        logic                      user;
    } axis_beat_t;

endpackage

`default_nettype wire

// ==== logic/axis_register.sv ====
/*
  Two-entry skid register for the beat stream.
  Breaks both the valid and the ready path with registers.
  Holds up to two beats under back-pressure and loses none.
*/
`default_nettype none

module axis_register import axis_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    // upstream side
    input  axis_beat_t s_beat,
    input  logic       s_valid,
    output logic       s_ready,
    // downstream side
    output axis_beat_t m_beat,
    output logic       m_valid,
    input  logic       m_ready
);

    // controller states
    localparam logic [1:0] ST_EMPTY = 2'd0;
    localparam logic [1:0] ST_ONE   = 2'd1;
    localparam logic [1:0] ST_TWO   = 2'd2;

    logic [1:0] state;
    logic [1:0] state_next;

    // handshake events
    logic in_xfer;
    logic out_xfer;

    // datapath steering
    logic in_to_out;
    logic in_to_skid;
    logic skid_to_out;

    // registered handshake outputs
    logic ready_q;
    logic valid_q;

    // beat registers
    axis_beat_t out_beat;
    axis_beat_t skid_beat;

    assign s_ready = ready_q;
    assign m_valid = valid_q;
    assign m_beat  = out_beat;

    always_comb begin
        // a transfer needs both sides of the handshake
        in_xfer  = s_valid & ready_q;
        out_xfer = valid_q & m_ready;

        in_to_out   = 1'b0;
        in_to_skid  = 1'b0;
        skid_to_out = 1'b0;
        state_next  = state;

        case (state)
            ST_EMPTY: begin
                // nothing held, new beat goes straight to the output
                if (in_xfer) begin
                    in_to_out  = 1'b1;
                    state_next = ST_ONE;
                end
            end
            ST_ONE: begin
                if (in_xfer && out_xfer) begin
                    // flow through, replace the output beat
                    in_to_out = 1'b1;
                end else if (in_xfer) begin
                    // output stalled, park the new beat
                    in_to_skid = 1'b1;
                    state_next = ST_TWO;
                end else if (out_xfer) begin
                    // drained with nothing behind it
                    state_next = ST_EMPTY;
                end
            end
            ST_TWO: begin
                // ready is low here, only the output can move
                if (out_xfer) begin
                    skid_to_out = 1'b1;
                    state_next  = ST_ONE;
                end
            end
            default: begin
                state_next = ST_EMPTY;
            end
        endcase
    end

    // control state
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= ST_EMPTY;
            ready_q <= 1'b0;
            valid_q <= 1'b0;
        end else begin
            state   <= state_next;
            // take more only while the skid entry is free
            ready_q <= (state_next != ST_TWO);
            // output holds a beat in every state but empty
            valid_q <= (state_next != ST_EMPTY);
        end
    end

    // beat storage
    always_ff @(posedge clk) begin
        if (in_to_out) begin
            out_beat <= s_beat;
        end else if (skid_to_out) begin
            out_beat <= skid_beat;
        end
        if (in_to_skid) begin
            skid_beat <= s_beat;
        end
    end

endmodule

`default_nettype wire

// ==== logic/frame_byte_counter.sv ====
/*
  Observes the middle stream link and counts bytes per frame.
  Beat, valid and ready pass through untouched.
  A status record strobes for one cycle after each last beat.
*/
`default_nettype none

`include "stream_defs.svh"

module frame_byte_counter import axis_pkg::*, frame_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    // from the input register
    input  axis_beat_t    s_beat,
    input  logic          s_valid,
    output logic          s_ready,
    // to the output register
    output axis_beat_t    m_beat,
    output logic          m_valid,
    input  logic          m_ready,
    // per-frame status strobe
    output frame_status_t status,
    output logic          status_valid
);

    // running totals of the frame in progress
    logic [`FRAME_BYTES_W-1:0] byte_acc;
    logic                      err_acc;
    logic [`FRAME_SEQ_W-1:0]   seq_num;

    // values including the current beat
    logic                      xfer;
    logic [`FRAME_BYTES_W-1:0] beat_bytes;
    logic [`FRAME_BYTES_W-1:0] frame_bytes;
    logic                      frame_err;

    // number of set keep bits, sparse keep counted bit by bit
    function automatic logic [`FRAME_BYTES_W-1:0] count_keep(
        input logic [`STREAM_KEEP_W-1:0] keep
    );
        logic [`FRAME_BYTES_W-1:0] n;
        n = '0;
        for (int i = 0; i < `STREAM_KEEP_W; i++) begin
            n = n + {{(`FRAME_BYTES_W-1){1'b0}}, keep[i]};
        end
        return n;
    endfunction

    // link passes straight through
    assign m_beat  = s_beat;
    assign m_valid = s_valid;
    assign s_ready = m_ready;

    always_comb begin
        xfer        = s_valid & m_ready;
        beat_bytes  = count_keep(s_beat.keep);
        frame_bytes = byte_acc + beat_bytes;
        frame_err   = err_acc | s_beat.user;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            byte_acc     <= '0;
            err_acc      <= 1'b0;
            seq_num      <= '0;
            status_valid <= 1'b0;
        end else begin
            status_valid <= 1'b0;
            if (xfer) begin
                if (s_beat.last) begin
                    // frame done, start over for the next one
                    byte_acc     <= '0;
                    err_acc      <= 1'b0;
                    seq_num      <= seq_num + 1'b1;
                    status_valid <= 1'b1;
                end else begin
                    byte_acc <= frame_bytes;
                    err_acc  <= frame_err;
                end
            end
        end
    end

    // record is captured on the same edge as the last beat
    always_ff @(posedge clk) begin
        if (xfer && s_beat.last) begin
            status.byte_count <= frame_bytes;
            status.error      <= frame_err;
            status.seq        <= seq_num;
        end
    end

endmodule

`default_nettype wire

// ==== logic/frame_pkg.sv ====
/*
  Per-frame status record produced by the byte counter.
  One record is strobed at the end of each frame.
  Import with a wildcard in the module header.
*/
`default_nettype none

`include "stream_defs.svh"

package frame_pkg;

    // status of one finished frame, 25 bits in all
    typedef struct packed {
        // sum of set keep bits over the frame
        logic [`FRAME_BYTES_W-1:0] byte_count;
        // OR of user over every beat of the frame
        logic                      error;
        // frame number, starts at 0 after reset
        logic [`FRAME_SEQ_W-1:0]   seq;
    } frame_status_t;

endpackage

`default_nettype wire

// ==== logic/stream_defs.svh ====
/*
  Width constants for the 64-bit stream monitor.
  Included by the packages, the counter and the testbench
  wherever the widths are needed.
*/
`ifndef STREAM_DEFS_SVH
`define STREAM_DEFS_SVH

// data bits per beat
`define STREAM_DATA_W 64

// one keep bit per data byte
`define STREAM_KEEP_W 8

// byte count per frame, wide enough for long frames
`define FRAME_BYTES_W 16

// frame sequence number, wraps around
`define FRAME_SEQ_W 8

`endif

// ==== logic/stream_monitor_top.sv ====
/*
  Top level of the frame monitor.
  Input skid register, byte counter, output skid register.
  Beats take two cycles end to end when the output is not stalled.
*/
`default_nettype none

module stream_monitor_top import axis_pkg::*, frame_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    // stream in
    input  axis_beat_t    s_beat,
    input  logic          s_valid,
    output logic          s_ready,
    // stream out
    output axis_beat_t    m_beat,
    output logic          m_valid,
    input  logic          m_ready,
    // frame status
    output frame_status_t status,
    output logic          status_valid
);

    // link from input register into the counter
    axis_beat_t mid_beat;
    logic       mid_valid;
    logic       mid_ready;

    // counter output toward the output register
    axis_beat_t cnt_beat;
    logic       cnt_valid;
    logic       cnt_ready;

    axis_register i_in_reg (
        .clk     (clk),
        .rst     (rst),
        .s_beat  (s_beat),
        .s_valid (s_valid),
        .s_ready (s_ready),
        .m_beat  (mid_beat),
        .m_valid (mid_valid),
        .m_ready (mid_ready)
    );

    // counts on the middle link without stalling it
    frame_byte_counter i_counter (
        .clk          (clk),
        .rst          (rst),
        .s_beat       (mid_beat),
        .s_valid      (mid_valid),
        .s_ready      (mid_ready),
        .m_beat       (cnt_beat),
        .m_valid      (cnt_valid),
        .m_ready      (cnt_ready),
        .status       (status),
        .status_valid (status_valid)
    );

    axis_register i_out_reg (
        .clk     (clk),
        .rst     (rst),
        .s_beat  (cnt_beat),
        .s_valid (cnt_valid),
        .s_ready (cnt_ready),
        .m_beat  (m_beat),
        .m_valid (m_valid),
        .m_ready (m_ready)
    );

endmodule

`default_nettype wire

// ==== stream_monitor.f ====
+incdir+logic
logic/axis_pkg.sv
logic/frame_pkg.sv
logic/axis_register.sv
logic/frame_byte_counter.sv
logic/stream_monitor_top.sv
tb/tb_clock_gen.sv
tb/tb_stream_monitor.sv

// ==== tb/tb_clock_gen.sv ====
/*
  Clock and reset source for the stream monitor testbench.
  clk has a period of 8, rst is high for the first two cycles
  and drops on a falling edge.
*/
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // release away from the rising edge
    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

`default_nettype wire

// ==== tb/tb_stream_monitor.sv ====
/*
  Table-driven testbench for the stream monitor.
  Frames from the table are driven on falling edges, and output beats
  and status records are checked on rising edges against queued
  expectations. A watchdog bounds the run.
*/
`default_nettype none

`include "stream_defs.svh"

module tb_stream_monitor import axis_pkg::*, frame_pkg::*; ();

    // one frame per row, user_beat 8'hFF means no beat carries user
    typedef struct packed {
        logic [7:0]                beats;
        logic [7:0]                last_keep;
        logic [7:0]                user_beat;
        logic [7:0]                gap;
        logic [15:0]               stall;
        logic                      rand_stall;
        logic                      bp;
        logic [`FRAME_BYTES_W-1:0] exp_bytes;
        logic                      exp_err;
    } row_t;

    typedef struct packed {
        axis_beat_t  beat;
        logic [31:0] cyc;
        logic        timed;
    } exp_beat_t;

    typedef struct packed {
        frame_status_t st;
        logic [31:0]   cyc;
        logic          timed;
    } exp_status_t;

    localparam int NUM_ROWS = 12;

    // beats, last keep, user beat, gap, stall, random stall, ready falls, bytes, error
    localparam row_t ROWS [NUM_ROWS] = '{
        '{8'd1,  8'hFF, 8'hFF, 8'h00, 16'h0000, 1'b0, 1'b0, 16'd8,  1'b0},
        '{8'd1,  8'h01, 8'hFF, 8'h00, 16'h0000, 1'b0, 1'b0, 16'd1,  1'b0},
        '{8'd4,  8'hFF, 8'hFF, 8'h00, 16'h0000, 1'b0, 1'b0, 16'd32, 1'b0},
        '{8'd5,  8'h0F, 8'd2,  8'h00, 16'h0000, 1'b0, 1'b0, 16'd36, 1'b1},
        '{8'd3,  8'h80, 8'd0,  8'h55, 16'h0000, 1'b0, 1'b0, 16'd17, 1'b1},
        '{8'd6,  8'h3F, 8'hFF, 8'h93, 16'h0000, 1'b0, 1'b0, 16'd46, 1'b0},
        '{8'd8,  8'h07, 8'd7,  8'h00, 16'hF0F0, 1'b0, 1'b0, 16'd59, 1'b1},
        '{8'd10, 8'hFF, 8'hFF, 8'h00, 16'hFFF0, 1'b0, 1'b1, 16'd80, 1'b0},
        '{8'd7,  8'h1F, 8'd3,  8'h00, 16'hAAAA, 1'b0, 1'b0, 16'd53, 1'b1},
        '{8'd9,  8'hC3, 8'hFF, 8'h24, 16'h0000, 1'b1, 1'b0, 16'd68, 1'b0},
        '{8'd12, 8'h01, 8'd11, 8'h00, 16'h0000, 1'b1, 1'b0, 16'd89, 1'b1},
        '{8'd2,  8'h80, 8'd1,  8'h11, 16'h0FF0, 1'b0, 1'b0, 16'd9,  1'b1}
    };

    logic          clk;
    logic          rst;
    axis_beat_t    s_beat;
    logic          s_valid;
    logic          s_ready;
    axis_beat_t    m_beat;
    logic          m_valid;
    logic          m_ready;
    frame_status_t status;
    logic          status_valid;

    // pushed by the driver, read by index in the monitors
    exp_beat_t   exp_beats[$];
    exp_status_t exp_status[$];
    int          out_idx = 0;
    int          stat_idx = 0;
    int          err_drv = 0;
    int          err_out = 0;
    int          err_stat = 0;
    logic [31:0] cycle = '0;

    // m_ready pattern of the frame in flight
    logic        stall_on = 1'b0;
    logic [15:0] stall_mask = '0;
    logic [3:0]  stall_phase = '0;

    tb_clock_gen i_clock_gen (
        .clk (clk),
        .rst (rst)
    );

    stream_monitor_top i_dut (
        .clk          (clk),
        .rst          (rst),
        .s_beat       (s_beat),
        .s_valid      (s_valid),
        .s_ready      (s_ready),
        .m_beat       (m_beat),
        .m_valid      (m_valid),
        .m_ready      (m_ready),
        .status       (status),
        .status_valid (status_valid)
    );

    // free-running count for latency checks
    always @(posedge clk) begin
        cycle <= cycle + 32'd1;
    end

    // a set mask bit stalls the output for that cycle
    task automatic drive_ready();
        if (stall_on) begin
            m_ready = ~stall_mask[stall_phase];
        end else begin
            m_ready = 1'b1;
        end
        stall_phase = stall_phase + 4'd1;
    endtask

    task automatic next_cycle();
        @(negedge clk);
        drive_ready();
    endtask

    always @(posedge clk) begin : check_output
        exp_beat_t e;
        if (!rst && m_valid && m_ready) begin
            assert (out_idx < exp_beats.size()) else begin
                $display("output beat at %0t arrived with no beat sent for it", $time);
                err_out = err_out + 1;
            end
            if (out_idx < exp_beats.size()) begin
                e = exp_beats[out_idx];
                assert (m_beat == e.beat) else begin
                    $display("FAILED at %0t: beat %0d got %h/%h/%b/%b, expected %h/%h/%b/%b",
                             $time, out_idx, m_beat.data, m_beat.keep, m_beat.last,
                             m_beat.user, e.beat.data, e.beat.keep, e.beat.last, e.beat.user);
                    err_out = err_out + 1;
                end
                // only frames without stalls have a fixed latency
                if (e.timed) begin
                    assert (cycle - e.cyc == 32'd2) else begin
                        $display("FAILED at %0t: beat %0d left %0d cycles after entry, expected 2",
                                 $time, out_idx, cycle - e.cyc);
                        err_out = err_out + 1;
                    end
                end
                out_idx = out_idx + 1;
            end
        end
    end

    always @(posedge clk) begin : check_status
        exp_status_t e;
        if (!rst && status_valid) begin
            assert (stat_idx < exp_status.size()) else begin
                $display("status strobe at %0t with no frame end pending", $time);
                err_stat = err_stat + 1;
            end
            if (stat_idx < exp_status.size()) begin
                e = exp_status[stat_idx];
                assert (status == e.st) else begin
                    $display("FAILED at %0t: status %0d got %0d/%b/%0d, expected %0d/%b/%0d",
                             $time, stat_idx, status.byte_count, status.error, status.seq,
                             e.st.byte_count, e.st.error, e.st.seq);
                    err_stat = err_stat + 1;
                end
                if (e.timed) begin
                    assert (cycle - e.cyc == 32'd2) else begin
                        $display("FAILED at %0t: status %0d came %0d cycles after last beat",
                                 $time, stat_idx, cycle - e.cyc);
                        err_stat = err_stat + 1;
                    end
                end
                stat_idx = stat_idx + 1;
            end
        end
    end

    initial begin : stimulus
        row_t        row;
        axis_beat_t  b;
        exp_beat_t   eb;
        exp_status_t es;
        integer      seed;
        logic [31:0] rnd;
        int          sum_bytes;
        logic        sum_err;
        logic        timed;
        logic        saw_low;
        logic [7:0]  seq_tb;
        logic [2:0]  gap_pos;
        int          err_before;
        int          total_err;

        seed    = 32'h4d33;
        seq_tb  = 8'd0;
        s_beat  = '0;
        s_valid = 1'b0;
        m_ready = 1'b0;

        // sample in the middle of reset, after the first full clock edge
        @(posedge clk);
        @(negedge clk);
        assert (!s_ready && !m_valid && !status_valid) else begin
            $display("FAILED at %0t: s_ready %b m_valid %b status_valid %b in reset, expected 0",
                     $time, s_ready, m_valid, status_valid);
            err_drv = err_drv + 1;
        end
        @(negedge rst);
        @(posedge clk);
        @(negedge clk);
        assert (s_ready && !m_valid && !status_valid) else begin
            $display("FAILED at %0t: s_ready %b m_valid %b status_valid %b after reset",
                     $time, s_ready, m_valid, status_valid);
            err_drv = err_drv + 1;
        end

        for (int r = 0; r < NUM_ROWS; r++) begin
            row        = ROWS[r];
            err_before = err_drv + err_out + err_stat;
            if (row.rand_stall) begin
                rnd = $random(seed);
                // phase 0 stays free so the output always drains
                stall_mask = rnd[15:0] & 16'hFFFE;
            end else begin
                stall_mask = row.stall;
            end
            stall_on    = (stall_mask != 16'h0000);
            stall_phase = 4'd0;
            timed       = ~stall_on;
            saw_low     = 1'b0;
            sum_bytes   = 0;
            sum_err     = 1'b0;
            drive_ready();

            for (int k = 0; k < int'(row.beats); k++) begin
                gap_pos = k[2:0];
                if (row.gap[gap_pos]) begin
                    s_valid = 1'b0;
                    next_cycle();
                end
                b.data    = {$random(seed), $random(seed)};
                b.last    = (k == int'(row.beats) - 1);
                b.keep    = b.last ? row.last_keep : 8'hFF;
                b.user    = (k == int'(row.user_beat));
                sum_bytes = sum_bytes + $countones(b.keep);
                sum_err   = sum_err | b.user;
                s_beat    = b;
                s_valid   = 1'b1;
                // ready is registered, so its value now holds at the next rising edge
                while (!s_ready) begin
                    saw_low = 1'b1;
                    next_cycle();
                end
                eb.beat  = b;
                eb.cyc   = cycle;
                eb.timed = timed;
                exp_beats.push_back(eb);
                if (b.last) begin
                    es.st.byte_count = row.exp_bytes;
                    es.st.error      = row.exp_err;
                    es.st.seq        = seq_tb;
                    es.cyc           = cycle;
                    es.timed         = timed;
                    exp_status.push_back(es);
                end
                next_cycle();
            end
            s_valid = 1'b0;

            // 8 bytes per full beat plus the last keep, error from any user beat
            assert (sum_bytes == int'(row.exp_bytes) && sum_err == row.exp_err) else begin
                $display("table row %0d does not agree with the beats it describes", r);
                err_drv = err_drv + 1;
            end

            while (out_idx < exp_beats.size() || stat_idx < exp_status.size()) begin
                next_cycle();
            end
            assert (s_ready) else begin
                $display("s_ready stayed low after frame %0d drained", r);
                err_drv = err_drv + 1;
            end
            if (row.bp) begin
                assert (saw_low) else begin
                    $display("s_ready never fell while the output stalled in frame %0d", r);
                    err_drv = err_drv + 1;
                end
            end
            stall_on = 1'b0;
            $display("frame %0d: %0d beats, %0d bytes, error %0b, seq %0d, %s at %0t",
                     r, row.beats, row.exp_bytes, row.exp_err, seq_tb,
                     (err_drv + err_out + err_stat == err_before) ? "ok" : "mismatch", $time);
            seq_tb = seq_tb + 8'd1;
        end

        total_err = err_drv + err_out + err_stat;
        $display("%0d frames, %0d of %0d beats, %0d status records, %0d errors",
                 NUM_ROWS, out_idx, exp_beats.size(), stat_idx, total_err);
        if (total_err == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // budget of 20 cycles per table beat plus setup
    initial begin : watchdog
        int total_beats;
        total_beats = 0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            total_beats = total_beats + int'(ROWS[i].beats);
        end
        repeat (total_beats * 20 + 200) @(posedge clk);
        $display("run timed out after %0d cycles, the stream stopped moving",
                 total_beats * 20 + 200);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire
